// File: par_mem_top.f
common/par_mem_pkg.sv
hdl/par_wrap.sv
hdl/par_ram.sv
hdl/par_mem_wb.sv
hdl/par_mem_regs.sv
hdl/par_mem_top.sv
tests/par_mem_checker.sv
tests/tb_par_mem.sv

// File: Makefile
# Verilator build and run of the parity protected scratch memory

SIM      := verilator
SIMFLAGS := --binary --timing -Wno-fatal
TOP      := tb_par_mem
FILELIST := par_mem_top.f
OBJDIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

# the run passes only if the pass line shows up in the output
test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)

// File: tests/tb_par_mem.sv
//--------------------------------------
// testbench top for the parity memory:
// clock, reset, random Wishbone stimulus,
// a line per test and the closing counts
//--------------------------------------
`timescale 1ns/10ps

module tb_par_mem;

  logic clk;
  logic rst;
  logic cyc_i;
  logic stb_i;
  logic we_i;
  logic [par_mem_pkg::WB_ADR_WIDTH-1:0] adr_i;
  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] dat_i;
  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] dat_o;
  logic ack_o;
  logic err_o;
  logic irq;

  int seed;
  int error_count;
  int check_count;
  int timeouts;
  // failures already charged to earlier tests
  int fails_seen;
  int tests_passed;
  int tests_failed;
  // memory addresses written by the random test, reads only go there
  logic [par_mem_pkg::ADDR_WIDTH-1:0] used_addr [$];

  par_mem_top u_par_mem_top (
    .clk   (clk),
    .rst   (rst),
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .we_i  (we_i),
    .adr_i (adr_i),
    .dat_i (dat_i),
    .dat_o (dat_o),
    .ack_o (ack_o),
    .err_o (err_o),
    .irq   (irq)
  );

  par_mem_checker u_par_mem_checker (
    .clk         (clk),
    .rst         (rst),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .err_o       (err_o),
    .irq         (irq),
    .error_count (error_count),
    .check_count (check_count)
  );

  always #5 clk = ~clk;

  function automatic logic [par_mem_pkg::WB_ADR_WIDTH-1:0] reg_adr(
      input par_mem_pkg::reg_addr_e off);
    return {1'b1, 5'd0, off};
  endfunction

  //--------------------------------------
  // one classic cycle, held until the slave ends it
  //--------------------------------------
  task automatic bus_cycle(input logic we, input logic [par_mem_pkg::WB_ADR_WIDTH-1:0] adr,
                           input logic [par_mem_pkg::WB_DAT_WIDTH-1:0] dat);
    int waited;
    @(negedge clk);
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i = we;
    adr_i = adr;
    dat_i = dat;
    waited = 0;
    @(negedge clk);
    while (ack_o !== 1'b1 && err_o !== 1'b1 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (ack_o !== 1'b1 && err_o !== 1'b1) begin
      timeouts++;
      $display("timeout: no ack_o or err_o within 20 cycles for address %h", adr);
    end
    // the next call waits one more falling edge, so stb_i stays low a cycle
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i = 1'b0;
  endtask

  task automatic end_test(input string name);
    int fails;
    // let the checker finish the last compare
    repeat (2) @(negedge clk);
    fails = error_count + timeouts - fails_seen;
    fails_seen = error_count + timeouts;
    if (fails == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d problems", name, fails);
    end
  endtask

  initial begin
    logic [par_mem_pkg::ADDR_WIDTH-1:0] a;
    logic [par_mem_pkg::WB_ADR_WIDTH-1:0] ra;
    int idx;
    seed = 47149;
    clk = 1'b0;
    rst = 1'b1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i = 1'b0;
    adr_i = '0;
    dat_i = '0;
    timeouts = 0;
    fails_seen = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // random writes and reads with injection off
    for (int i = 0; i < 64; i++) begin
      if (used_addr.size() == 0 || ($random(seed) & 1) == 0) begin
        a = par_mem_pkg::ADDR_WIDTH'($random(seed));
        bus_cycle(1'b1, {1'b0, a}, $random(seed));
        used_addr.push_back(a);
      end else begin
        idx = $unsigned($random(seed)) % used_addr.size();
        bus_cycle(1'b0, {1'b0, used_addr[idx]}, '0);
      end
    end
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_ERR_CNT), '0);
    end_test("random write and read");

    // single shot, only the first write after arming carries bad parity
    a = par_mem_pkg::ADDR_WIDTH'($random(seed));
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_CTRL), 32'h3);
    bus_cycle(1'b1, {1'b0, a}, $random(seed));
    bus_cycle(1'b0, {1'b0, a}, '0);
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_ERR_CNT), '0);
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_ERR_ADDR), '0);
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_CTRL), '0);
    bus_cycle(1'b1, {1'b0, a}, $random(seed));
    bus_cycle(1'b0, {1'b0, a}, '0);
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_CTRL), '0);
    end_test("single shot injection");

    // persistent injection over eight addresses, then run the counter into its top
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_ERR_CNT), '0);
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_CTRL), 32'h1);
    a = par_mem_pkg::ADDR_WIDTH'($random(seed));
    for (int i = 0; i < 8; i++) bus_cycle(1'b1, {1'b0, a + 7'(i)}, $random(seed));
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_CTRL), '0);
    for (int i = 0; i < 8; i++) bus_cycle(1'b0, {1'b0, a + 7'(i)}, '0);
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_ERR_CNT), '0);
    for (int i = 0; i < 260; i++) bus_cycle(1'b0, {1'b0, a + 7'(i % 8)}, '0);
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_ERR_CNT), '0);
    end_test("persistent injection");

    // status flag and irq, reusing the corrupted words from the last test
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_STATUS), 32'h1);
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_ERR_CNT), '0);
    bus_cycle(1'b0, {1'b0, a}, '0);
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_STATUS), '0);
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_CTRL), 32'h4);
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_STATUS), 32'h0);
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_STATUS), 32'h1);
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_STATUS), '0);
    bus_cycle(1'b0, {1'b0, a + 7'd1}, '0);
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_ERR_CNT), $random(seed));
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_ERR_CNT), '0);
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_STATUS), 32'h1);
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_CTRL), '0);
    end_test("status and interrupt");

    // control readback, then unmapped offsets which must read zero
    for (int i = 0; i < 8; i++) begin
      bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_CTRL), $random(seed));
      bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_CTRL), '0);
    end
    bus_cycle(1'b1, reg_adr(par_mem_pkg::REG_CTRL), '0);
    for (int i = 0; i < 8; i++) begin
      ra = {1'b1, 5'(($unsigned($random(seed)) % 31) + 1), 2'($random(seed))};
      bus_cycle(1'b1, ra, $random(seed));
      bus_cycle(1'b0, ra, '0);
    end
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_STATUS), '0);
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_ERR_ADDR), '0);
    bus_cycle(1'b0, reg_adr(par_mem_pkg::REG_CTRL), '0);
    end_test("register readback");

    $display("summary: %0d tests passed, %0d failed, %0d cycles checked, %0d errors, %0d timeouts",
             tests_passed, tests_failed, check_count, error_count, timeouts);
    if (tests_failed == 0 && error_count == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: tests/par_mem_checker.sv
//--------------------------------------
// bus monitor for the parity memory:
// reference model of the memory, the bad
// parity flags and every register, with
// a compare at the end of each bus cycle
//--------------------------------------
`timescale 1ns/10ps

module par_mem_checker (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 cyc_i,
  input  logic                                 stb_i,
  input  logic                                 we_i,
  input  logic [par_mem_pkg::WB_ADR_WIDTH-1:0] adr_i,
  input  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] dat_i,
  input  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] dat_o,
  input  logic                                 ack_o,
  input  logic                                 err_o,
  input  logic                                 irq,
  output int                                   error_count,
  output int                                   check_count
);

  // model memory with a written flag and a bad parity flag per address
  logic [par_mem_pkg::DATA_WIDTH-1:0] mem_m [par_mem_pkg::MEM_DEPTH];
  bit written_m [par_mem_pkg::MEM_DEPTH];
  bit corrupt_m [par_mem_pkg::MEM_DEPTH];
  // model registers
  bit inj_en_m;
  bit inj_once_m;
  bit irq_en_m;
  bit flag_m;
  int cnt_m;
  logic [par_mem_pkg::ADDR_WIDTH-1:0] err_addr_m;
  // the cycle in flight and what it should end with
  bit active;
  bit busy;
  bit exp_err;
  bit check_data;
  bit unknown;
  int lat;
  int exp_lat;
  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] exp_data;
  logic [par_mem_pkg::ADDR_WIDTH-1:0] cur_addr;

  task automatic report(input string msg);
    $display("error %0t: %s", $time, msg);
    error_count++;
  endtask

  // register contents as software should see them, unused bits zero
  function automatic logic [par_mem_pkg::WB_DAT_WIDTH-1:0] reg_value(input logic [1:0] off);
    logic [par_mem_pkg::WB_DAT_WIDTH-1:0] v;
    v = '0;
    case (off)
      par_mem_pkg::REG_CTRL: v[2:0] = {irq_en_m, inj_once_m, inj_en_m};
      par_mem_pkg::REG_STATUS: v[0] = flag_m;
      par_mem_pkg::REG_ERR_CNT: v = par_mem_pkg::WB_DAT_WIDTH'(cnt_m);
      default: v[par_mem_pkg::ADDR_WIDTH-1:0] = err_addr_m;
    endcase
    return v;
  endfunction

  task automatic write_register(input logic [1:0] off,
                                input logic [par_mem_pkg::WB_DAT_WIDTH-1:0] d);
    case (off)
      par_mem_pkg::REG_CTRL: begin
        inj_en_m = d[0];
        inj_once_m = d[1];
        irq_en_m = d[2];
      end
      // the flag only clears on a 1 in bit 0
      par_mem_pkg::REG_STATUS: if (d[0]) flag_m = 1'b0;
      par_mem_pkg::REG_ERR_CNT: cnt_m = 0;
      default: ;
    endcase
  endtask

  // called at the edge where the slave accepts the request
  task automatic sample_request();
    logic [par_mem_pkg::ADDR_WIDTH-1:0] a;
    a = adr_i[par_mem_pkg::ADDR_WIDTH-1:0];
    busy = 1'b1;
    lat = 1;
    exp_lat = 1;
    exp_err = 1'b0;
    check_data = 1'b0;
    unknown = 1'b0;
    exp_data = '0;
    cur_addr = a;
    if (adr_i[par_mem_pkg::WB_ADR_WIDTH-1]) begin
      // register space, offsets 4 and up are unmapped and read zero
      if (adr_i[par_mem_pkg::WB_ADR_WIDTH-2:2] != '0) begin
        check_data = !we_i;
      end else if (we_i) begin
        write_register(adr_i[1:0], dat_i);
      end else begin
        check_data = 1'b1;
        exp_data = reg_value(adr_i[1:0]);
      end
    end else if (we_i) begin
      mem_m[a] = dat_i[par_mem_pkg::DATA_WIDTH-1:0];
      written_m[a] = 1'b1;
      // injection spoils the stored parity, single shot disarms after one write
      corrupt_m[a] = inj_en_m;
      if (inj_once_m) inj_en_m = 1'b0;
    end else begin
      exp_lat = 2;
      unknown = !written_m[a];
      exp_err = corrupt_m[a];
      check_data = written_m[a] && !corrupt_m[a];
      exp_data = par_mem_pkg::WB_DAT_WIDTH'(mem_m[a]);
    end
  endtask

  task automatic end_cycle();
    check_count++;
    if (ack_o && err_o) report("ack_o and err_o high together");
    if (lat != exp_lat) begin
      report($sformatf("response after %0d cycles, expected %0d", lat, exp_lat));
    end
    if (!unknown && err_o !== exp_err) begin
      report($sformatf("address %h ended with err_o %b, expected %b", cur_addr, err_o, exp_err));
    end
    if (check_data && ack_o && dat_o !== exp_data) begin
      report($sformatf("dat_o %h, expected %h", dat_o, exp_data));
    end
    // a failed read sets the flag, counts up to the top and latches the address
    if (exp_err || (unknown && err_o === 1'b1)) begin
      flag_m = 1'b1;
      if (cnt_m < (1 << par_mem_pkg::ERR_CNT_WIDTH) - 1) cnt_m++;
      err_addr_m = cur_addr;
    end
    busy = 1'b0;
  endtask

  // requests are taken at the rising edge, results compared at the falling edge
  initial begin
    error_count = 0;
    check_count = 0;
    forever begin
      @(posedge clk);
      if (rst) begin
        active = 1'b0;
        busy = 1'b0;
        inj_en_m = 1'b0;
        inj_once_m = 1'b0;
        irq_en_m = 1'b0;
        flag_m = 1'b0;
        cnt_m = 0;
        err_addr_m = '0;
      end else begin
        active = 1'b1;
        if (busy) lat++;
        else if (cyc_i && stb_i) sample_request();
      end
      @(negedge clk);
      if (active) begin
        // irq is checked before this cycle's error reaches the model
        if (irq !== (flag_m && irq_en_m)) begin
          report($sformatf("irq is %b, expected %b", irq, flag_m && irq_en_m));
        end
        if (ack_o === 1'b1 || err_o === 1'b1) begin
          if (busy) end_cycle();
          else report("ack_o or err_o without a request");
        end
      end
    end
  end

endmodule

// File: hdl/par_mem_top.sv
//--------------------------------------
// top level of the parity protected
// scratch memory: bus controller,
// registers, parity wrapper and RAM
//--------------------------------------
`timescale 1ns/10ps

module par_mem_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 cyc_i,
  input  logic                                 stb_i,
  input  logic                                 we_i,
  input  logic [par_mem_pkg::WB_ADR_WIDTH-1:0] adr_i,
  input  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] dat_i,
  output logic [par_mem_pkg::WB_DAT_WIDTH-1:0] dat_o,
  output logic                                 ack_o,
  output logic                                 err_o,
  output logic                                 irq
);

  // memory path between controller, parity wrapper and array
  logic                                 mem_we;
  logic                                 mem_re;
  logic [par_mem_pkg::ADDR_WIDTH-1:0]   mem_addr;
  logic [par_mem_pkg::DATA_WIDTH-1:0]   mem_wdata;
  logic [par_mem_pkg::DATA_WIDTH-1:0]   mem_rdata;
  logic [par_mem_pkg::STORE_WIDTH-1:0]  store_wdata;
  logic [par_mem_pkg::STORE_WIDTH-1:0]  store_rdata;
  logic                                 par_error;

  // register path
  logic                                 reg_we;
  logic                                 reg_re;
  par_mem_pkg::reg_addr_e               reg_addr;
  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] reg_wdata;
  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] reg_rdata;

  // error reporting and injection control
  logic                                 err_event;
  logic [par_mem_pkg::ADDR_WIDTH-1:0]   err_addr;
  logic                                 inj_used;
  logic                                 cfg_errorinj;

  par_mem_wb u_par_mem_wb (
    .clk       (clk),
    .rst       (rst),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .we_i      (we_i),
    .adr_i     (adr_i),
    .dat_i     (dat_i),
    .mem_rdata (mem_rdata),
    .par_error (par_error),
    .reg_rdata (reg_rdata),
    .dat_o     (dat_o),
    .ack_o     (ack_o),
    .err_o     (err_o),
    .mem_we    (mem_we),
    .mem_re    (mem_re),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .reg_we    (reg_we),
    .reg_re    (reg_re),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .err_event (err_event),
    .err_addr  (err_addr),
    .inj_used  (inj_used)
  );

  par_mem_regs u_par_mem_regs (
    .clk          (clk),
    .rst          (rst),
    .reg_we       (reg_we),
    .reg_re       (reg_re),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .err_event    (err_event),
    .err_addr     (err_addr),
    .inj_used     (inj_used),
    .reg_rdata    (reg_rdata),
    .cfg_errorinj (cfg_errorinj),
    .irq          (irq)
  );

  // parity is generated and checked around the raw array
  par_wrap u_par_wrap (
    .wdata_in     (mem_wdata),
    .rdata_in     (store_rdata),
    .cfg_errorinj (cfg_errorinj),
    .wdata_out    (store_wdata),
    .rdata_out    (mem_rdata),
    .error        (par_error)
  );

  par_ram u_par_ram (
    .clk   (clk),
    .we    (mem_we),
    .re    (mem_re),
    .addr  (mem_addr),
    .wdata (store_wdata),
    .rdata (store_rdata)
  );

endmodule

// File: hdl/par_mem_regs.sv
//--------------------------------------
// control and status registers: error
// injection control, sticky error flag,
// error counter, error address and irq
//--------------------------------------
`timescale 1ns/10ps

module par_mem_regs (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 reg_we,
  input  logic                                 reg_re,
  input  par_mem_pkg::reg_addr_e               reg_addr,
  input  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] reg_wdata,
  input  logic                                 err_event,
  input  logic [par_mem_pkg::ADDR_WIDTH-1:0]   err_addr,
  input  logic                                 inj_used,
  output logic [par_mem_pkg::WB_DAT_WIDTH-1:0] reg_rdata,
  output logic                                 cfg_errorinj,
  output logic                                 irq
);

  // control bits
  logic inj_en;
  logic inj_once;
  logic irq_en;
  // sticky flag, set by a failed read and cleared by writing 1
  logic err_flag;
  logic [par_mem_pkg::ERR_CNT_WIDTH-1:0] err_cnt;
  logic [par_mem_pkg::ADDR_WIDTH-1:0]    err_addr_q;

  logic wr_ctrl;
  logic wr_status;
  logic wr_cnt;

  assign wr_ctrl = reg_we && (reg_addr == par_mem_pkg::REG_CTRL);
  assign wr_status = reg_we && (reg_addr == par_mem_pkg::REG_STATUS);
  assign wr_cnt = reg_we && (reg_addr == par_mem_pkg::REG_ERR_CNT);

  //--------------------------------------
  // control register
  //--------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      inj_en <= 1'b0;
      inj_once <= 1'b0;
      irq_en <= 1'b0;
    end else if (wr_ctrl) begin
      inj_en <= reg_wdata[par_mem_pkg::CTRL_INJ_EN];
      inj_once <= reg_wdata[par_mem_pkg::CTRL_INJ_ONCE];
      irq_en <= reg_wdata[par_mem_pkg::CTRL_IRQ_EN];
    end else if (inj_used && inj_once) begin
      // single shot mode drops the enable once one write carried bad parity
      // inj_once itself stays set so software can rearm with inj_en alone
      inj_en <= 1'b0;
    end
  end

  //--------------------------------------
  // error tracking
  //--------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      err_flag <= 1'b0;
      err_cnt <= '0;
      err_addr_q <= '0;
    end else begin
      // a new error wins over a clear in the same cycle
      if (err_event) begin
        err_flag <= 1'b1;
      end else if (wr_status && reg_wdata[par_mem_pkg::STATUS_ERR]) begin
        err_flag <= 1'b0;
      end

      // any write clears the counter, otherwise count up and stick at the top
      if (wr_cnt) begin
        err_cnt <= '0;
      end else if (err_event && (err_cnt != '1)) begin
        err_cnt <= err_cnt + 1'b1;
      end

      if (err_event) begin
        err_addr_q <= err_addr;
      end
    end
  end

  //--------------------------------------
  // readback and outputs
  //--------------------------------------
  always_comb begin
    // unused bits read zero
    reg_rdata = '0;
    if (reg_re) begin
      case (reg_addr)
        par_mem_pkg::REG_CTRL: begin
          reg_rdata[par_mem_pkg::CTRL_INJ_EN] = inj_en;
          reg_rdata[par_mem_pkg::CTRL_INJ_ONCE] = inj_once;
          reg_rdata[par_mem_pkg::CTRL_IRQ_EN] = irq_en;
        end
        par_mem_pkg::REG_STATUS: reg_rdata[par_mem_pkg::STATUS_ERR] = err_flag;
        par_mem_pkg::REG_ERR_CNT: reg_rdata[par_mem_pkg::ERR_CNT_WIDTH-1:0] = err_cnt;
        par_mem_pkg::REG_ERR_ADDR: reg_rdata[par_mem_pkg::ADDR_WIDTH-1:0] = err_addr_q;
        default: reg_rdata = '0;
      endcase
    end
  end

  assign cfg_errorinj = inj_en;
  // level interrupt, masked by irq_en
  assign irq = err_flag && irq_en;

endmodule

// File: hdl/par_mem_wb.sv
//--------------------------------------
// wishbone classic slave controller
// decodes memory and register accesses,
// issues the strobes and ends each cycle
//--------------------------------------
`timescale 1ns/10ps

module par_mem_wb (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  cyc_i,
  input  logic                                  stb_i,
  input  logic                                  we_i,
  input  logic [par_mem_pkg::WB_ADR_WIDTH-1:0]  adr_i,
  input  logic [par_mem_pkg::WB_DAT_WIDTH-1:0]  dat_i,
  input  logic [par_mem_pkg::DATA_WIDTH-1:0]    mem_rdata,
  input  logic                                  par_error,
  input  logic [par_mem_pkg::WB_DAT_WIDTH-1:0]  reg_rdata,
  output logic [par_mem_pkg::WB_DAT_WIDTH-1:0]  dat_o,
  output logic                                  ack_o,
  output logic                                  err_o,
  output logic                                  mem_we,
  output logic                                  mem_re,
  output logic [par_mem_pkg::ADDR_WIDTH-1:0]    mem_addr,
  output logic [par_mem_pkg::DATA_WIDTH-1:0]    mem_wdata,
  output logic                                  reg_we,
  output logic                                  reg_re,
  output par_mem_pkg::reg_addr_e                reg_addr,
  output logic [par_mem_pkg::WB_DAT_WIDTH-1:0]  reg_wdata,
  output logic                                  err_event,
  output logic [par_mem_pkg::ADDR_WIDTH-1:0]    err_addr,
  output logic                                  inj_used
);

  par_mem_pkg::wb_state_e state;
  par_mem_pkg::wb_state_e state_nxt;

  logic req;
  logic mem_sel;
  // register space hit, offsets above 3 are unmapped and read zero
  logic reg_hit;
  // response payload and the address of the read in flight
  logic [par_mem_pkg::WB_DAT_WIDTH-1:0] dat_q;
  logic [par_mem_pkg::ADDR_WIDTH-1:0]   addr_q;
  // parity failure captured in MEM_READ
  logic err_q;

  assign req = cyc_i && stb_i;
  assign mem_sel = !adr_i[par_mem_pkg::WB_ADR_WIDTH-1];
  assign reg_hit = !mem_sel && (adr_i[par_mem_pkg::WB_ADR_WIDTH-2:2] == '0);

  // address and data go straight to the memory path, the strobes qualify them
  assign mem_addr = adr_i[par_mem_pkg::ADDR_WIDTH-1:0];
  assign mem_wdata = dat_i[par_mem_pkg::DATA_WIDTH-1:0];
  assign reg_addr = par_mem_pkg::reg_addr_e'(adr_i[1:0]);
  assign reg_wdata = dat_i;

  //--------------------------------------
  // next state and strobe decode
  //--------------------------------------
  always_comb begin
    state_nxt = state;
    mem_we = 1'b0;
    mem_re = 1'b0;
    reg_we = 1'b0;
    reg_re = 1'b0;
    case (state)
      par_mem_pkg::IDLE: begin
        // strobes only leave IDLE, so a held request cannot fire twice
        if (req) begin
          if (mem_sel) begin
            mem_we = we_i;
            mem_re = !we_i;
            state_nxt = we_i ? par_mem_pkg::RESP : par_mem_pkg::MEM_READ;
          end else begin
            reg_we = we_i && reg_hit;
            reg_re = !we_i && reg_hit;
            state_nxt = par_mem_pkg::RESP;
          end
        end
      end
      // the read register is loaded, parity is valid in this cycle
      par_mem_pkg::MEM_READ: state_nxt = par_mem_pkg::RESP;
      par_mem_pkg::RESP: state_nxt = par_mem_pkg::IDLE;
      default: state_nxt = par_mem_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= par_mem_pkg::IDLE;
      err_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == par_mem_pkg::IDLE) begin
        err_q <= 1'b0;
      end else if (state == par_mem_pkg::MEM_READ) begin
        err_q <= par_error;
      end
    end
  end

  // response data, zero extended to the bus width
  always_ff @(posedge clk) begin
    if (state == par_mem_pkg::IDLE && req) begin
      addr_q <= adr_i[par_mem_pkg::ADDR_WIDTH-1:0];
      // register reads return in the same cycle, writes answer zero
      dat_q <= reg_re ? reg_rdata : '0;
    end else if (state == par_mem_pkg::MEM_READ) begin
      dat_q <= par_mem_pkg::WB_DAT_WIDTH'(mem_rdata);
    end
  end

  //--------------------------------------
  // cycle termination
  //--------------------------------------
  assign dat_o = dat_q;
  assign ack_o = (state == par_mem_pkg::RESP) && !err_q;
  assign err_o = (state == par_mem_pkg::RESP) && err_q;
  // error event lines up with err_o so the counter bumps in that cycle
  assign err_event = err_o;
  assign err_addr = addr_q;
  // every memory write consumes a pending single shot injection
  assign inj_used = mem_we;

endmodule

// File: hdl/par_ram.sv
//--------------------------------------
// single port storage array holding data
// and parity, synchronous write and a
// registered read port
//--------------------------------------
`timescale 1ns/10ps

module par_ram (
  input  logic                                clk,
  input  logic                                we,
  input  logic                                re,
  input  logic [par_mem_pkg::ADDR_WIDTH-1:0]  addr,
  input  logic [par_mem_pkg::STORE_WIDTH-1:0] wdata,
  output logic [par_mem_pkg::STORE_WIDTH-1:0] rdata
);

  // contents are undefined until written
  logic [par_mem_pkg::STORE_WIDTH-1:0] mem [par_mem_pkg::MEM_DEPTH];

  // write commits on the edge where we is seen
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // the read register only loads on re and otherwise holds its value
  // so the parity check downstream sees a stable word
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[addr];
    end
  end

endmodule

// File: hdl/par_wrap.sv
//--------------------------------------
// parity wrapper around the storage array
// generates odd parity per slice on writes
// and checks it on reads, with injection
//--------------------------------------
`timescale 1ns/10ps

module par_wrap (
  input  logic [par_mem_pkg::DATA_WIDTH-1:0]  wdata_in,
  input  logic [par_mem_pkg::STORE_WIDTH-1:0] rdata_in,
  input  logic                                cfg_errorinj,
  output logic [par_mem_pkg::STORE_WIDTH-1:0] wdata_out,
  output logic [par_mem_pkg::DATA_WIDTH-1:0]  rdata_out,
  output logic                                error
);

  // data padded up to a whole number of slices
  logic [par_mem_pkg::PAD_WIDTH-1:0] pad_wdata;
  logic [par_mem_pkg::PAD_WIDTH-1:0] pad_rdata;
  // parity generated for the write word
  logic [par_mem_pkg::PAR_WIDTH-1:0] wpar;
  // parity as it came back out of the array
  logic [par_mem_pkg::PAR_WIDTH-1:0] rpar;
  // one mismatch flag per slice
  logic [par_mem_pkg::PAR_WIDTH-1:0] slice_err;

  //--------------------------------------
  // padding and per slice reduction
  //--------------------------------------
  always_comb begin
    // the top slice is filled with zeros, which do not change parity
    pad_wdata = '0;
    pad_wdata[par_mem_pkg::DATA_WIDTH-1:0] = wdata_in;
    // injection flips bit 0 only inside the parity computation
    // so the stored data stays intact and only the parity goes bad
    pad_wdata[0] = pad_wdata[0] ^ cfg_errorinj;

    pad_rdata = '0;
    pad_rdata[par_mem_pkg::DATA_WIDTH-1:0] = rdata_in[par_mem_pkg::DATA_WIDTH-1:0];
    rpar = rdata_in[par_mem_pkg::STORE_WIDTH-1 -: par_mem_pkg::PAR_WIDTH];

    for (int s = 0; s < par_mem_pkg::PAR_WIDTH; s++) begin
      // odd parity: slice plus its parity bit holds an odd number of ones
      wpar[s] = ~(^pad_wdata[s*par_mem_pkg::SLICE_WIDTH +: par_mem_pkg::SLICE_WIDTH]);
      // an even count on readback means the slice is corrupted
      slice_err[s] = ~(^{rpar[s],
                         pad_rdata[s*par_mem_pkg::SLICE_WIDTH +: par_mem_pkg::SLICE_WIDTH]});
    end
  end

  //--------------------------------------
  // outputs
  //--------------------------------------

  // parity is appended above the payload
  assign wdata_out = {wpar, wdata_in};
  // the payload is returned unmodified, no correction is attempted
  assign rdata_out = rdata_in[par_mem_pkg::DATA_WIDTH-1:0];
  // any failing slice fails the whole word
  assign error = |slice_err;

endmodule

// File: common/par_mem_pkg.sv
//--------------------------------------
// shared widths and depth of the parity
// protected scratch memory, register map
// and bus controller state encoding
//--------------------------------------
package par_mem_pkg;

  //--------------------------------------
  // memory geometry
  //--------------------------------------

  // payload bits of one memory word
  localparam int DATA_WIDTH = 17;
  // one odd parity bit per slice
  localparam int PAR_WIDTH = 2;
  // bits covered by each parity bit, the top slice is zero padded
  localparam int SLICE_WIDTH = (DATA_WIDTH + PAR_WIDTH - 1) / PAR_WIDTH;
  // padded data width used for the per slice reduction
  localparam int PAD_WIDTH = PAR_WIDTH * SLICE_WIDTH;
  // parity sits above the data in the stored word
  localparam int STORE_WIDTH = DATA_WIDTH + PAR_WIDTH;
  localparam int MEM_DEPTH = 128;
  localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);

  //--------------------------------------
  // bus and register widths
  //--------------------------------------

  // the top address bit selects the register space
  localparam int WB_ADR_WIDTH = 8;
  localparam int WB_DAT_WIDTH = 32;
  // the error counter saturates at its all ones value
  localparam int ERR_CNT_WIDTH = 8;

  // bit positions inside the control and status registers
  localparam int CTRL_INJ_EN = 0;
  localparam int CTRL_INJ_ONCE = 1;
  localparam int CTRL_IRQ_EN = 2;
  localparam int STATUS_ERR = 0;

  // register offsets, decoded from address bits 1:0
  typedef enum logic [1:0] {
    REG_CTRL     = 2'd0,
    REG_STATUS   = 2'd1,
    REG_ERR_CNT  = 2'd2,
    REG_ERR_ADDR = 2'd3
  } reg_addr_e;

  // wishbone controller states
  typedef enum logic [1:0] {
    IDLE,
    MEM_READ,
    RESP
  } wb_state_e;

endpackage
